// File: verilog/qla_pkg.sv
// ----------------------------------------
// shared constants for the qla register bus
// address spaces, offsets, dac and safety codes
// register address union, write bus and current structs
// ----------------------------------------

package qla_pkg;

    // ----------------------------------------
    // sizes
    localparam int NUM_CHAN       = 4;          // axes on the board
    localparam int DAC_FRAME_BITS = 24;         // quad dac frame length
    localparam int BUF_DEPTH      = 64;         // data buffer words
    localparam int BUF_AW         = $clog2(BUF_DEPTH);

    // ----------------------------------------
    // address map, addr[15:12] is the space
    localparam logic [3:0] ADDR_MAIN     = 4'h0;
    localparam logic [3:0] ADDR_DATA_BUF = 4'h7;

    // per-channel offsets, addr[3:0]
    localparam logic [3:0] OFF_ADC_DATA = 4'h0;    // feedback readback
    localparam logic [3:0] OFF_DAC_CTRL = 4'h1;    // current command
    localparam logic [3:0] OFF_STATUS   = 4'h0;    // channel 0 only

    // buffer index that maps to the control/status word
    localparam logic [11:0] BUF_STATUS_INDEX = 12'hFFF;

    // ----------------------------------------
    // current codes, offset binary around mid scale
    localparam logic [15:0] DAC_MID       = 16'h8000;  // zero current
    localparam logic [15:0] SAFETY_MARGIN = 16'h0100;  // slack over 2x cmd
    localparam logic [3:0]  DAC_CMD       = 4'b0011;   // write and update

    // ----------------------------------------
    // register address, two decodes of the same 16 bits
    typedef struct packed {
        logic [3:0] space;
        logic [3:0] unused;
        logic [3:0] chan;    // 0 = board, 1..4 = axes
        logic [3:0] offset;
    } chan_addr_t;

    typedef struct packed {
        logic [3:0]  space;
        logic [11:0] index;  // buffer word or status index
    } buf_addr_t;

    typedef union packed {
        chan_addr_t chan;
        buf_addr_t  databuf;
    } reg_addr_t;

    // internal write bus, one pulse per apb write
    typedef struct packed {
        logic        wen;
        reg_addr_t   waddr;
        logic [31:0] wdata;
    } reg_wr_t;

    // sampled feedback, fb[0] is axis 1
    typedef struct packed {
        logic                       valid;
        logic [NUM_CHAN-1:0][15:0]  fb;
    } cur_fb_t;

    // commands, index 0 is axis 1
    typedef logic [NUM_CHAN-1:0][15:0] cur_cmd_t;

endpackage

// File: verilog/reg_bus_bridge.sv
// ----------------------------------------
// apb slave to internal register bus
// write pulse, read mux by space, slave error
// ----------------------------------------

`timescale 1ns/1ps

module reg_bus_bridge
    import qla_pkg::*;
(
    input  logic        sysclk,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [15:0] paddr,
    input  logic [31:0] pwdata,
    output logic        pready,
    output logic [31:0] prdata,
    output logic        pslverr,
    output reg_wr_t     reg_wr,
    output reg_addr_t   raddr,
    input  logic [31:0] main_chan0_rdata,
    input  logic [31:0] axis_rdata,
    input  logic [31:0] buf_rdata
);

    logic access;      // apb access phase
    logic mapped;      // space has a decoder behind it

    assign raddr  = paddr;
    assign access = psel & penable;
    assign mapped = (raddr.chan.space == ADDR_MAIN) ||
                    (raddr.chan.space == ADDR_DATA_BUF);

    assign pready  = access;             // no wait states
    assign pslverr = access & ~mapped;

    // write bus follows the access cycle directly
    assign reg_wr.wen   = access & pwrite & mapped;
    assign reg_wr.waddr = raddr;
    assign reg_wr.wdata = pwdata;

    // ----------------------------------------
    // read mux
    always_comb begin
        if (raddr.chan.space == ADDR_DATA_BUF)
            prdata = buf_rdata;
        else if (raddr.chan.space == ADDR_MAIN)
            prdata = (raddr.chan.chan == 4'd0) ? main_chan0_rdata : axis_rdata;
        else
            prdata = '0;                 // unmapped reads as zero
    end

    // write strobes need a setup phase in between
    a_wen_single : assert property (@(posedge sysclk) disable iff (reset)
        reg_wr.wen |=> !reg_wr.wen);

endmodule

// File: verilog/axis_regs.sv
// ----------------------------------------
// per-axis command and feedback registers
// command writes raise cmd_changed for the dac
// ----------------------------------------

`timescale 1ns/1ps

module axis_regs
    import qla_pkg::*;
(
    input  logic        sysclk,
    input  logic        reset,
    input  reg_wr_t     reg_wr,
    input  reg_addr_t   raddr,
    input  cur_fb_t     cur_fb,
    output logic [31:0] rdata,
    output cur_cmd_t    cur_cmd,
    output logic [3:0]  cmd_changed
);

    logic [NUM_CHAN-1:0][15:0] fb_q;   // latest feedback per axis
    logic       wr_axis;               // write lands on an axis
    logic       rd_axis;
    logic [1:0] wr_sel;                // axis index, chan minus one
    logic [1:0] rd_sel;

    // channels 1..4 only, channel 0 belongs to the board
    assign wr_axis = reg_wr.wen && (reg_wr.waddr.chan.space == ADDR_MAIN) &&
                     (reg_wr.waddr.chan.chan != 4'd0) &&
                     (reg_wr.waddr.chan.chan <= NUM_CHAN) &&
                     (reg_wr.waddr.chan.offset == OFF_DAC_CTRL);
    assign rd_axis = (raddr.chan.chan != 4'd0) && (raddr.chan.chan <= NUM_CHAN);

    // low two bits minus one, chan 4 wraps to 3
    assign wr_sel = reg_wr.waddr.chan.chan[1:0] - 2'd1;
    assign rd_sel = raddr.chan.chan[1:0] - 2'd1;

    // ----------------------------------------
    // registers
    always_ff @(posedge sysclk) begin
        if (reset) begin
            cur_cmd     <= {NUM_CHAN{DAC_MID}};   // zero current
            fb_q        <= '0;
            cmd_changed <= '0;
        end else begin
            cmd_changed <= '0;                    // single-cycle strobe
            if (cur_fb.valid)
                fb_q <= cur_fb.fb;
            if (wr_axis) begin
                cur_cmd[wr_sel]     <= reg_wr.wdata[15:0];  // high half dropped
                cmd_changed[wr_sel] <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // read port
    always_comb begin
        rdata = '0;
        if (rd_axis) begin
            case (raddr.chan.offset)
                OFF_ADC_DATA: rdata = {16'd0, fb_q[rd_sel]};
                OFF_DAC_CTRL: rdata = {16'd0, cur_cmd[rd_sel]};
                default:      rdata = '0;
            endcase
        end
    end

endmodule

// File: verilog/dac_spi.sv
// ----------------------------------------
// quad dac serializer
// pending flags per axis, 24-bit spi frames
// ----------------------------------------

`timescale 1ns/1ps

module dac_spi
    import qla_pkg::*;
(
    input  logic       sysclk,
    input  logic       reset,
    input  cur_cmd_t   cur_cmd,
    input  logic [3:0] cmd_changed,
    output logic       dac_sclk,
    output logic       dac_mosi,
    output logic       dac_csel
);

    logic [3:0]                pending;     // axes waiting for a frame
    logic [3:0]                pend_next;
    logic [1:0]                sel;         // lowest pending axis
    logic                      sel_vld;
    logic [DAC_FRAME_BITS-1:0] shift_q;
    logic [4:0]                bit_cnt;     // bits already clocked out

    // new changes merge into the queue, repeats coalesce
    always_comb begin
        pend_next = pending | cmd_changed;
        sel       = '0;
        sel_vld   = 1'b0;
        for (int i = NUM_CHAN - 1; i >= 0; i--) begin
            if (pend_next[i]) begin
                sel     = i[1:0];
                sel_vld = 1'b1;
            end
        end
    end

    assign dac_mosi = shift_q[DAC_FRAME_BITS-1];   // msb first

    // ----------------------------------------
    // frame sequencer
    always_ff @(posedge sysclk) begin
        if (reset) begin
            pending  <= '0;
            dac_csel <= 1'b1;
            dac_sclk <= 1'b0;
            bit_cnt  <= '0;
            shift_q  <= '0;
        end else if (dac_csel) begin
            // idle, start the lowest pending axis
            pending <= pend_next;
            if (sel_vld) begin
                pending[sel] <= 1'b0;
                shift_q  <= {DAC_CMD, 2'b00, sel, cur_cmd[sel]};  // value taken now
                dac_csel <= 1'b0;
                bit_cnt  <= '0;
            end
        end else begin
            pending  <= pend_next;       // keep collecting while busy
            dac_sclk <= ~dac_sclk;       // sysclk / 2
            if (dac_sclk) begin
                // falling edge, next bit onto mosi
                shift_q <= shift_q << 1;
                bit_cnt <= bit_cnt + 5'd1;
                if (bit_cnt == DAC_FRAME_BITS - 1)
                    dac_csel <= 1'b1;    // frame done
            end
        end
    end

    a_sclk_idle : assert property (@(posedge sysclk) disable iff (reset)
        dac_csel |-> !dac_sclk);

endmodule

// File: verilog/safety_check.sv
// ----------------------------------------
// single-axis overcurrent check
// latched amplifier disable
// ----------------------------------------

`timescale 1ns/1ps

module safety_check
    import qla_pkg::*;
(
    input  logic        sysclk,
    input  logic        reset,
    input  logic        cur_fb_valid,
    input  logic [15:0] fb,
    input  logic [15:0] cmd,
    input  logic        clear,         // from board status write
    output logic        amp_disable
);

    logic [15:0] fb_mag;       // |fb - mid|
    logic [15:0] cmd_mag;      // |cmd - mid|
    logic [17:0] limit;        // 2 * cmd_mag + margin, no overflow
    logic        violation;

    // codes are offset binary around zero current
    assign fb_mag  = (fb >= DAC_MID)  ? (fb - DAC_MID)  : (DAC_MID - fb);
    assign cmd_mag = (cmd >= DAC_MID) ? (cmd - DAC_MID) : (DAC_MID - cmd);

    assign limit     = {1'b0, cmd_mag, 1'b0} + {2'b00, SAFETY_MARGIN};
    assign violation = {2'b00, fb_mag} > limit;

    // ----------------------------------------
    // latch until cleared, clear wins
    always_ff @(posedge sysclk) begin
        if (reset)
            amp_disable <= 1'b0;
        else if (clear)
            amp_disable <= 1'b0;
        else if (cur_fb_valid && violation)
            amp_disable <= 1'b1;
    end

endmodule

// File: verilog/board_regs.sv
// ----------------------------------------
// channel 0 board status/control
// power enable, amplifier enables, board id
// ----------------------------------------

`timescale 1ns/1ps

module board_regs
    import qla_pkg::*;
(
    input  logic        sysclk,
    input  logic        reset,
    input  reg_wr_t     reg_wr,
    input  reg_addr_t   raddr,
    input  logic [3:0]  board_id,
    input  logic [3:0]  amp_disable,
    output logic [31:0] rdata,
    output logic [3:0]  safety_clear,
    output logic [3:0]  amp_en
);

    logic       pwr_enable;
    logic [3:0] amp_en_reg;    // host requested enables
    logic       status_wr;
    logic       pwr_on_wr;     // power enable written 1
    logic [3:0] amp_mask;      // wdata[11:8]
    logic [3:0] amp_val;       // wdata[3:0]

    assign status_wr = reg_wr.wen && (reg_wr.waddr.chan.space == ADDR_MAIN) &&
                       (reg_wr.waddr.chan.chan == 4'd0) &&
                       (reg_wr.waddr.chan.offset == OFF_STATUS);
    assign amp_mask  = reg_wr.wdata[11:8];
    assign amp_val   = reg_wr.wdata[3:0];
    assign pwr_on_wr = reg_wr.wdata[18] & reg_wr.wdata[19];

    // ----------------------------------------
    // masked writes
    always_ff @(posedge sysclk) begin
        if (reset) begin
            pwr_enable <= 1'b0;
            amp_en_reg <= '0;
        end else if (status_wr) begin
            if (reg_wr.wdata[18])                   // power mask
                pwr_enable <= reg_wr.wdata[19];
            for (int i = 0; i < NUM_CHAN; i++) begin
                if (amp_mask[i])
                    amp_en_reg[i] <= amp_val[i];
            end
        end
    end

    // re-enabling an axis, or the power, releases its latch
    assign safety_clear = status_wr ? ((amp_mask & amp_val) | {4{pwr_on_wr}}) : 4'd0;

    // amplifier runs only when all three agree
    assign amp_en = {4{pwr_enable}} & amp_en_reg & ~amp_disable;

    // ----------------------------------------
    // status readback
    always_comb begin
        if (raddr.chan.offset == OFF_STATUS)
            rdata = {4'd0, board_id, 4'd0, pwr_enable, 7'd0,
                     amp_disable, 4'd0, amp_en_reg};
        else
            rdata = '0;
    end

endmodule

// File: verilog/data_buffer.sv
// ----------------------------------------
// circular feedback sample buffer
// one selected axis, status word at index 0xfff
// ----------------------------------------

`timescale 1ns/1ps

module data_buffer
    import qla_pkg::*;
(
    input  logic        sysclk,
    input  logic        reset,
    input  reg_wr_t     reg_wr,
    input  reg_addr_t   raddr,
    input  cur_fb_t     cur_fb,
    output logic [31:0] rdata
);

    logic [15:0]       mem [BUF_DEPTH];   // sample storage
    logic [BUF_AW-1:0] ptr;               // next write slot
    logic [2:0]        buf_chan;          // 1..4
    logic [1:0]        fb_sel;            // chan minus one
    logic              ctrl_wr;
    logic [2:0]        new_chan;

    assign ctrl_wr  = reg_wr.wen && (reg_wr.waddr.databuf.space == ADDR_DATA_BUF) &&
                      (reg_wr.waddr.databuf.index == BUF_STATUS_INDEX);
    assign new_chan = reg_wr.wdata[2:0];
    assign fb_sel   = buf_chan[1:0] - 2'd1;    // chan 4 wraps to 3

    // ----------------------------------------
    // control, channel select and pointer
    always_ff @(posedge sysclk) begin
        if (reset) begin
            ptr      <= '0;
            buf_chan <= 3'd1;
        end else begin
            if (cur_fb.valid)
                ptr <= ptr + 1'b1;               // wraps at depth
            if (ctrl_wr) begin
                if (new_chan >= 3'd1 && new_chan <= NUM_CHAN)
                    buf_chan <= new_chan;        // others ignored
                if (reg_wr.wdata[31])
                    ptr <= '0;                   // restart wins over step
            end
        end
    end

    // sample store
    always_ff @(posedge sysclk) begin
        if (cur_fb.valid)
            mem[ptr] <= cur_fb.fb[fb_sel];
    end

    // ----------------------------------------
    // read port
    always_comb begin
        if (raddr.databuf.index == BUF_STATUS_INDEX)
            rdata = {10'd0, ptr, 13'd0, buf_chan};
        else
            rdata = {16'd0, mem[raddr.databuf.index[BUF_AW-1:0]]};
    end

endmodule

// File: verilog/qla_top.sv
// ----------------------------------------
// qla top level
// apb bridge, axis registers, dac serializer,
// per-axis safety checks, board regs, data buffer
// ----------------------------------------

`timescale 1ns/1ps

module qla_top
    import qla_pkg::*;
(
    input  logic        sysclk,
    input  logic        reset,
    // apb slave
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [15:0] paddr,
    input  logic [31:0] pwdata,
    output logic        pready,
    output logic [31:0] prdata,
    output logic        pslverr,
    // board side
    input  cur_fb_t     cur_fb,        // converted feedback, one-cycle valid
    input  logic [3:0]  board_id,      // rotary switch
    output logic        dac_sclk,
    output logic        dac_mosi,
    output logic        dac_csel,
    output logic [3:0]  amp_en
);

    reg_wr_t     reg_wr;               // shared write bus
    reg_addr_t   raddr;                // shared read address
    logic [31:0] main_chan0_rdata;
    logic [31:0] axis_rdata;
    logic [31:0] buf_rdata;
    cur_cmd_t    cur_cmd;
    logic [3:0]  cmd_changed;
    logic [3:0]  amp_disable;          // latched by safety checks
    logic [3:0]  safety_clear;         // from board status writes

    // ----------------------------------------
    // register bus
    reg_bus_bridge bridge (
        .sysclk(sysclk), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .pready(pready), .prdata(prdata), .pslverr(pslverr),
        .reg_wr(reg_wr), .raddr(raddr),
        .main_chan0_rdata(main_chan0_rdata),
        .axis_rdata(axis_rdata),
        .buf_rdata(buf_rdata)
    );

    // ----------------------------------------
    // current path
    axis_regs axes (
        .sysclk(sysclk), .reset(reset),
        .reg_wr(reg_wr), .raddr(raddr), .cur_fb(cur_fb),
        .rdata(axis_rdata), .cur_cmd(cur_cmd), .cmd_changed(cmd_changed)
    );

    dac_spi dac (
        .sysclk(sysclk), .reset(reset),
        .cur_cmd(cur_cmd), .cmd_changed(cmd_changed),
        .dac_sclk(dac_sclk), .dac_mosi(dac_mosi), .dac_csel(dac_csel)
    );

    // one comparator per axis
    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_safe
        safety_check safe (
            .sysclk(sysclk), .reset(reset),
            .cur_fb_valid(cur_fb.valid),
            .fb(cur_fb.fb[i]),
            .cmd(cur_cmd[i]),
            .clear(safety_clear[i]),
            .amp_disable(amp_disable[i])
        );
    end

    // ----------------------------------------
    // channel 0 and sample buffer
    board_regs chan0 (
        .sysclk(sysclk), .reset(reset),
        .reg_wr(reg_wr), .raddr(raddr), .board_id(board_id),
        .amp_disable(amp_disable), .rdata(main_chan0_rdata),
        .safety_clear(safety_clear), .amp_en(amp_en)
    );

    data_buffer data_buf (
        .sysclk(sysclk), .reset(reset),
        .reg_wr(reg_wr), .raddr(raddr), .cur_fb(cur_fb),
        .rdata(buf_rdata)
    );

endmodule

// File: tests/tb_qla.sv
// ----------------------------------------
// testbench for qla_top
// random apb and feedback stimulus, register model,
// dac frame capture, buffer replay and checks
// ----------------------------------------

`timescale 1ns/1ps

module tb_qla
    import qla_pkg::*;
();

    localparam int NUM_TXN        = 300;
    // about 6 cycles per transaction, frames and drain, then margin
    localparam int TIMEOUT_CYCLES = NUM_TXN * 10 + 2000;

    logic        sysclk = 1'b0;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [15:0] paddr;
    logic [31:0] pwdata;
    logic        pready;
    logic [31:0] prdata;
    logic        pslverr;
    cur_fb_t     cur_fb;
    logic [3:0]  board_id;
    logic        dac_sclk;
    logic        dac_mosi;
    logic        dac_csel;
    logic [3:0]  amp_en;

    integer seed;
    int     cycles = 0;
    int     error_count = 0;

    // ----------------------------------------
    // reference model state
    logic [15:0] m_cmd [NUM_CHAN];
    logic [15:0] m_fb [NUM_CHAN];
    logic        m_changed [NUM_CHAN];   // axis got a command write
    logic        m_pwr;
    logic [3:0]  m_en;
    logic [3:0]  m_dis;                  // latched disables
    logic [15:0] m_mem [BUF_DEPTH];
    logic        m_wr [BUF_DEPTH];       // slot holds a sample
    int          m_ptr;
    int          m_chan;

    // dac capture
    logic [15:0] snap_cmd [NUM_CHAN];    // model commands at frame start
    logic [15:0] last_frame [NUM_CHAN];
    logic        seen [NUM_CHAN];
    logic [23:0] frame_word;
    int          frame_bits;
    logic        frame_open = 1'b0;

    qla_top UUT (
        .sysclk(sysclk), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .pready(pready), .prdata(prdata), .pslverr(pslverr),
        .cur_fb(cur_fb), .board_id(board_id),
        .dac_sclk(dac_sclk), .dac_mosi(dac_mosi), .dac_csel(dac_csel),
        .amp_en(amp_en)
    );

    always #4 sysclk = ~sysclk;          // 8 ns period

    always @(posedge sysclk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the test did not finish", cycles);
            $display("Simulation failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // ----------------------------------------
    // helpers
    task compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            error_count++;
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // distance from zero current
    function automatic int magnitude(input logic [15:0] code);
        return (code >= 16'h8000) ? int'(code) - 32'h8000 : 32'h8000 - int'(code);
    endfunction

    function automatic logic over_limit(input logic [15:0] fb, input logic [15:0] cmd);
        return magnitude(fb) > 2 * magnitude(cmd) + int'(SAFETY_MARGIN);
    endfunction

    function automatic logic [31:0] status_word();
        return {4'd0, board_id, 4'd0, m_pwr, 7'd0, m_dis, 4'd0, m_en};
    endfunction

    function automatic logic [3:0] expected_amp_en();
        return {4{m_pwr}} & m_en & ~m_dis;
    endfunction

    // one apb transfer, called and returning at a falling edge
    task apb_access(input logic wr, input logic [15:0] addr, input logic [31:0] data,
                    output logic [31:0] rd, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge sysclk);
        penable = 1'b1;
        #2;                              // mid low phase, outputs settled
        compare_value("pready", 32'd1, {31'd0, pready});
        rd  = prdata;
        err = pslverr;
        @(negedge sysclk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task write_reg(input logic [15:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        logic        mapped;
        logic [3:0]  clr;
        int          c;
        apb_access(1'b1, addr, data, rd, err);
        mapped = (addr[15:12] == ADDR_MAIN) || (addr[15:12] == ADDR_DATA_BUF);
        c      = addr[7:4];
        compare_value("pslverr", {31'd0, !mapped}, {31'd0, err});
        if (addr[15:12] == ADDR_MAIN) begin
            if (c == 0 && addr[3:0] == OFF_STATUS) begin
                if (data[18])
                    m_pwr = data[19];
                m_en  = (m_en & ~data[11:8]) | (data[3:0] & data[11:8]);
                clr   = (data[11:8] & data[3:0]) | {4{data[18] & data[19]}};
                m_dis = m_dis & ~clr;    // re-enable releases the latch
            end else if (c >= 1 && c <= NUM_CHAN && addr[3:0] == OFF_DAC_CTRL) begin
                m_cmd[c-1]     = data[15:0];
                m_changed[c-1] = 1'b1;
            end
        end else if (addr[15:12] == ADDR_DATA_BUF && addr[11:0] == BUF_STATUS_INDEX) begin
            if (data[2:0] >= 1 && data[2:0] <= NUM_CHAN)
                m_chan = data[2:0];
            if (data[31])
                m_ptr = 0;
        end
        compare_value("amp_en", {28'd0, expected_amp_en()}, {28'd0, amp_en});
    endtask

    task read_reg(input logic [15:0] addr, output logic [31:0] rd);
        logic [31:0] exp;
        logic        err;
        logic        known;
        logic [3:0]  sp;
        int          c;
        int          idx;
        apb_access(1'b0, addr, 32'd0, rd, err);
        sp    = addr[15:12];
        c     = addr[7:4];
        exp   = '0;                      // unmapped reads as zero
        known = 1'b1;
        if (sp == ADDR_MAIN) begin
            if (c == 0)
                exp = (addr[3:0] == OFF_STATUS) ? status_word() : 32'd0;
            else if (addr[3:0] == OFF_ADC_DATA)
                exp = {16'd0, m_fb[c-1]};
            else if (addr[3:0] == OFF_DAC_CTRL)
                exp = {16'd0, m_cmd[c-1]};
        end else if (sp == ADDR_DATA_BUF) begin
            if (addr[11:0] == BUF_STATUS_INDEX) begin
                exp = {10'd0, 6'(m_ptr), 13'd0, 3'(m_chan)};
            end else begin
                idx   = addr[11:0] % BUF_DEPTH;
                known = m_wr[idx];       // memory has no reset
                exp   = {16'd0, m_mem[idx]};
            end
        end
        compare_value("pslverr", {31'd0, sp != ADDR_MAIN && sp != ADDR_DATA_BUF}, {31'd0, err});
        if (known)
            compare_value($sformatf("prdata@%h", addr), exp, rd);
    endtask

    // one feedback word, magnitudes spread around each axis limit
    task feed_sample(input int gap);
        logic [15:0] v [NUM_CHAN];
        logic [31:0] rd;
        int          lim;
        int          fm;
        repeat (gap) @(negedge sysclk);
        for (int i = 0; i < NUM_CHAN; i++) begin
            lim = 2 * magnitude(m_cmd[i]) + int'(SAFETY_MARGIN);
            fm  = lim - 128 + ({$random(seed)} % 256);
            if (fm > 32767)
                fm = 32767;
            v[i] = ({$random(seed)} % 2) ? 16'h8000 + 16'(fm) : 16'h8000 - 16'(fm);
            cur_fb.fb[i] = v[i];
        end
        cur_fb.valid = 1'b1;
        @(negedge sysclk);
        cur_fb.valid = 1'b0;
        for (int i = 0; i < NUM_CHAN; i++) begin
            if (over_limit(v[i], m_cmd[i]))
                m_dis[i] = 1'b1;
            m_fb[i] = v[i];
        end
        m_mem[m_ptr] = v[m_chan-1];
        m_wr[m_ptr]  = 1'b1;
        m_ptr        = (m_ptr + 1) % BUF_DEPTH;
        compare_value("amp_en", {28'd0, expected_amp_en()}, {28'd0, amp_en});
        read_reg(16'h0000, rd);          // disables through the status word
    endtask

    task random_txn();
        logic [31:0] d;
        logic [31:0] rd;
        logic [3:0]  sp;
        int          op;
        int          c;
        op = {$random(seed)} % 10;
        c  = 1 + {$random(seed)} % NUM_CHAN;
        d  = $random(seed);
        case (op)
            0, 1: begin
                d[15:0] = 16'h8000 + 16'($random(seed) % 8192);   // near mid scale
                write_reg({ADDR_MAIN, 4'd0, 4'(c), OFF_DAC_CTRL}, d);
            end
            2: write_reg(16'h0000, d);
            3: write_reg({ADDR_DATA_BUF, BUF_STATUS_INDEX}, d);
            4: read_reg({ADDR_MAIN, 4'd0, 4'(c), 4'({$random(seed)} % 4)}, rd);
            5: read_reg(16'h0000, rd);
            6: begin
                if (d[2:0] == 3'd0)
                    read_reg({ADDR_DATA_BUF, BUF_STATUS_INDEX}, rd);
                else
                    read_reg({ADDR_DATA_BUF, d[27:16]}, rd);
            end
            7: begin
                sp = d[15:12];
                if (sp == ADDR_MAIN || sp == ADDR_DATA_BUF)
                    sp = 4'h3;
                if (d[16])
                    write_reg({sp, d[11:0]}, d);
                else
                    read_reg({sp, d[11:0]}, rd);
            end
            default: feed_sample({$random(seed)} % 4);
        endcase
    endtask

    // select axis 3, restart, then read the samples back in order
    task buffer_replay();
        logic [15:0] exp_q [$];
        logic [31:0] rd;
        write_reg({ADDR_DATA_BUF, BUF_STATUS_INDEX}, 32'h8000_0003);
        for (int n = 0; n < 12; n++) begin
            feed_sample({$random(seed)} % 3);
            exp_q.push_back(m_fb[2]);
        end
        for (int n = 0; n < 12; n++) begin
            read_reg({ADDR_DATA_BUF, 12'(n)}, rd);
            compare_value("buf_word", {16'd0, exp_q[n]}, rd);
        end
        read_reg({ADDR_DATA_BUF, BUF_STATUS_INDEX}, rd);
        compare_value("buf_status", {10'd0, 6'd12, 13'd0, 3'd3}, rd);
    endtask

    // ----------------------------------------
    // dac frame capture
    always @(negedge dac_csel) begin
        if (!reset) begin
            frame_open = 1'b1;
            frame_bits = 0;
            frame_word = '0;
            for (int i = 0; i < NUM_CHAN; i++)
                snap_cmd[i] = m_cmd[i];
        end
    end

    always @(posedge dac_sclk) begin
        if (frame_open) begin
            frame_word = {frame_word[22:0], dac_mosi};   // msb first
            frame_bits++;
        end
    end

    always @(posedge dac_csel) begin
        if (frame_open) begin
            frame_open = 1'b0;
            compare_value("dac_frame_bits", DAC_FRAME_BITS, frame_bits);
            compare_value("dac_frame_cmd", {28'd0, DAC_CMD}, {28'd0, frame_word[23:20]});
            compare_value("dac_frame_addr_hi", 32'd0, {30'd0, frame_word[19:18]});
            compare_value("dac_frame_value", {16'd0, snap_cmd[frame_word[17:16]]},
                          {16'd0, frame_word[15:0]});
            last_frame[frame_word[17:16]] = frame_word[15:0];
            seen[frame_word[17:16]]       = 1'b1;
        end
    end

    // ----------------------------------------
    // main sequence
    initial begin
        int idle;
        seed     = 32'hfb95;
        reset    = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        cur_fb   = '0;
        board_id = 4'ha;
        m_pwr    = 1'b0;
        m_en     = '0;
        m_dis    = '0;
        m_ptr    = 0;
        m_chan   = 1;
        for (int i = 0; i < NUM_CHAN; i++) begin
            m_cmd[i]     = DAC_MID;
            m_fb[i]      = '0;
            m_changed[i] = 1'b0;
            seen[i]      = 1'b0;
        end
        for (int i = 0; i < BUF_DEPTH; i++)
            m_wr[i] = 1'b0;
        repeat (8) @(negedge sysclk);
        reset = 1'b0;

        write_reg(16'h0000, 32'h000C_0F0F);   // power and all amps on
        for (int n = 0; n < NUM_TXN; n++)
            random_txn();
        buffer_replay();

        // drain until the serializer stays idle
        idle = 0;
        while (idle < 3) begin
            @(negedge sysclk);
            idle = dac_csel ? idle + 1 : 0;
        end
        for (int i = 0; i < NUM_CHAN; i++) begin
            if (m_changed[i]) begin
                compare_value($sformatf("dac_seen_ch%0d", i + 1), 32'd1, {31'd0, seen[i]});
                compare_value($sformatf("dac_last_frame_ch%0d", i + 1),
                              {16'd0, m_cmd[i]}, {16'd0, last_frame[i]});
            end
        end

        if (error_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: filelist.f
verilog/qla_pkg.sv
verilog/reg_bus_bridge.sv
verilog/axis_regs.sv
verilog/dac_spi.sv
verilog/safety_check.sv
verilog/board_regs.sv
verilog/data_buffer.sv
verilog/qla_top.sv
tests/tb_qla.sv
